/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= csr_unit_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/csr_counters.sv */
module csr_counters (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               commit_valid,
    output logic [csr_pkg::PERF_CTR_BITS-1:0]  mcycle,
    output logic [csr_pkg::PERF_CTR_BITS-1:0]  minstret
);

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle <= mcycle + 1'b1;
            if (commit_valid) begin
                minstret <= minstret + 1'b1;
            end
        end
    end

endmodule

/* design/csr_fcsr_bank.sv */
module csr_fcsr_bank #(
    parameter int NUM_WARPS = 4,
    localparam int NW_BITS  = csr_pkg::idx_bits(NUM_WARPS)
) (
    input  logic                               clk,
    input  logic                               reset,
    input  csr_pkg::csr_reg_e                  wr_reg,
    input  logic [NW_BITS-1:0]                 wr_wid,
    input  csr_pkg::word_t                     wr_value,
    input  logic                               fpu_flags_valid,
    input  logic [NW_BITS-1:0]                 fpu_flags_wid,
    input  logic [csr_pkg::FFLAGS_BITS-1:0]    fpu_fflags,
    input  csr_pkg::csr_reg_e                  rd_reg,
    input  logic [NW_BITS-1:0]                 rd_wid,
    input  logic [NW_BITS-1:0]                 fpu_read_wid,
    output csr_pkg::word_t                     fcsr_rdata,
    output logic [csr_pkg::FRM_BITS-1:0]       fpu_frm
);

    localparam int FFB = csr_pkg::FFLAGS_BITS;
    localparam int FCB = csr_pkg::FCSR_BITS;

    // Per warp, frm above fflags
    logic [NUM_WARPS-1:0][FCB-1:0] fcsr;

    // Core write comes last so it overrides a same-cycle FPU update
    always_ff @(posedge clk) begin
        if (reset) begin
            fcsr <= '0;
        end else begin
            if (fpu_flags_valid) begin
                fcsr[fpu_flags_wid][FFB-1:0] <= fcsr[fpu_flags_wid][FFB-1:0] | fpu_fflags;
            end
            case (wr_reg)
                csr_pkg::REG_FFLAGS: fcsr[wr_wid][FFB-1:0]   <= wr_value[FFB-1:0];
                csr_pkg::REG_FRM:    fcsr[wr_wid][FCB-1:FFB] <= wr_value[csr_pkg::FRM_BITS-1:0];
                csr_pkg::REG_FCSR:   fcsr[wr_wid]            <= wr_value[FCB-1:0];
                default: ;
            endcase
        end
    end

    // Zero when the read targets some other register
    always_comb begin
        case (rd_reg)
            csr_pkg::REG_FFLAGS: fcsr_rdata = csr_pkg::word_t'(fcsr[rd_wid][FFB-1:0]);
            csr_pkg::REG_FRM:    fcsr_rdata = csr_pkg::word_t'(fcsr[rd_wid][FCB-1:FFB]);
            csr_pkg::REG_FCSR:   fcsr_rdata = csr_pkg::word_t'(fcsr[rd_wid]);
            default:             fcsr_rdata = '0;
        endcase
    end

    assign fpu_frm = fcsr[fpu_read_wid][FCB-1:FFB];

endmodule

/* design/csr_machine_regs.sv */
module csr_machine_regs (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::csr_reg_e  wr_reg,
    input  csr_pkg::word_t     wr_value,
    input  csr_pkg::csr_reg_e  rd_reg,
    output csr_pkg::word_t     machine_rdata
);

    localparam int NUM_MREGS = csr_pkg::REG_PMPADDR0 - csr_pkg::REG_SATP + 1;
    localparam int IDX_BITS  = $clog2(NUM_MREGS);

    // satp, mstatus, medeleg, mideleg, mie, mtvec, mepc, pmpcfg0, pmpaddr0
    csr_pkg::word_t mregs [NUM_MREGS];

    logic                wr_hit;
    logic                rd_hit;
    logic [IDX_BITS-1:0] wr_idx;
    logic [IDX_BITS-1:0] rd_idx;

    // Machine registers sit at the top of the enum
    assign wr_hit = (wr_reg >= csr_pkg::REG_SATP);
    assign rd_hit = (rd_reg >= csr_pkg::REG_SATP);
    assign wr_idx = IDX_BITS'(wr_reg - csr_pkg::REG_SATP);
    assign rd_idx = IDX_BITS'(rd_reg - csr_pkg::REG_SATP);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_MREGS; i++) begin
                mregs[i] <= '0;
            end
        end else if (wr_hit) begin
            mregs[wr_idx] <= wr_value;
        end
    end

    assign machine_rdata = rd_hit ? mregs[rd_idx] : '0;

endmodule

/* design/csr_pkg.sv */
package csr_pkg;

    localparam int CSR_ADDR_BITS = 12;
    localparam int XLEN          = 32;
    localparam int FFLAGS_BITS   = 5;
    localparam int FRM_BITS      = 3;
    localparam int FCSR_BITS     = FRM_BITS + FFLAGS_BITS;
    localparam int PERF_CTR_BITS = 44;

    typedef logic [XLEN-1:0] word_t;

    // Floating-point CSRs
    localparam logic [CSR_ADDR_BITS-1:0] CSR_FFLAGS     = 12'h001;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_FRM        = 12'h002;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_FCSR       = 12'h003;

    // Machine registers
    localparam logic [CSR_ADDR_BITS-1:0] CSR_SATP       = 12'h180;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MSTATUS    = 12'h300;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MISA       = 12'h301;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MEDELEG    = 12'h302;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MIDELEG    = 12'h303;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MIE        = 12'h304;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MTVEC      = 12'h305;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MEPC       = 12'h341;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_PMPCFG0    = 12'h3A0;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_PMPADDR0   = 12'h3B0;

    // Counters
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MCYCLE     = 12'hB00;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MINSTRET   = 12'hB02;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MCYCLE_H   = 12'hB80;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MINSTRET_H = 12'hB82;

    localparam logic [CSR_ADDR_BITS-1:0] CSR_MVENDORID  = 12'hF11;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MARCHID    = 12'hF12;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MIMPID     = 12'hF13;

    // Thread and warp identity, user read-only custom range
    localparam logic [CSR_ADDR_BITS-1:0] CSR_WTID       = 12'hCC0;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_LTID       = 12'hCC1;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_GTID       = 12'hCC2;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_LWID       = 12'hCC3;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_GWID       = 12'hCC4;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_GCID       = 12'hCC5;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_TMASK      = 12'hCC6;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_NT         = 12'hCC8;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_NW         = 12'hCC9;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_NC         = 12'hCCA;

    // MXL=1 (RV32), extensions I, M, F
    localparam word_t MISA_VALUE        = 32'h4000_1120;
    localparam word_t VENDOR_ID         = 32'h0000_0000;
    localparam word_t ARCHITECTURE_ID   = 32'h0000_0001;
    localparam word_t IMPLEMENTATION_ID = 32'h0000_0001;

    // Machine registers must stay contiguous from REG_SATP to REG_PMPADDR0
    typedef enum logic [3:0] {
        REG_NONE, REG_FFLAGS, REG_FRM, REG_FCSR,
        REG_SATP, REG_MSTATUS, REG_MEDELEG, REG_MIDELEG,
        REG_MIE, REG_MTVEC, REG_MEPC, REG_PMPCFG0, REG_PMPADDR0
    } csr_reg_e;

    function automatic int idx_bits(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    function automatic csr_reg_e csr_decode(input logic [CSR_ADDR_BITS-1:0] addr);
        case (addr)
            CSR_FFLAGS:   return REG_FFLAGS;
            CSR_FRM:      return REG_FRM;
            CSR_FCSR:     return REG_FCSR;
            CSR_SATP:     return REG_SATP;
            CSR_MSTATUS:  return REG_MSTATUS;
            CSR_MEDELEG:  return REG_MEDELEG;
            CSR_MIDELEG:  return REG_MIDELEG;
            CSR_MIE:      return REG_MIE;
            CSR_MTVEC:    return REG_MTVEC;
            CSR_MEPC:     return REG_MEPC;
            CSR_PMPCFG0:  return REG_PMPCFG0;
            CSR_PMPADDR0: return REG_PMPADDR0;
            default:      return REG_NONE;
        endcase
    endfunction

endpackage

/* design/csr_read_mux.sv */
module csr_read_mux #(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS   = 4,
    parameter int NUM_CORES   = 1,
    parameter int CORE_ID     = 0,
    localparam int NW_BITS    = csr_pkg::idx_bits(NUM_WARPS)
) (
    input  logic                                       read_enable,
    input  logic [NW_BITS-1:0]                         read_wid,
    input  logic [NUM_THREADS-1:0]                     read_tmask,
    input  logic [csr_pkg::CSR_ADDR_BITS-1:0]          read_addr,
    input  csr_pkg::word_t                             fcsr_rdata,
    input  csr_pkg::word_t                             machine_rdata,
    input  logic [csr_pkg::PERF_CTR_BITS-1:0]          mcycle,
    input  logic [csr_pkg::PERF_CTR_BITS-1:0]          minstret,
    output csr_pkg::csr_reg_e                          rd_reg,
    output logic [NW_BITS-1:0]                         rd_wid,
    output logic [NUM_THREADS-1:0][csr_pkg::XLEN-1:0]  read_data,
    output logic                                       read_error
);

    localparam int CTR = csr_pkg::PERF_CTR_BITS;

    localparam csr_pkg::word_t NT_WORD   = csr_pkg::word_t'(NUM_THREADS);
    localparam csr_pkg::word_t NW_WORD   = csr_pkg::word_t'(NUM_WARPS);
    localparam csr_pkg::word_t NC_WORD   = csr_pkg::word_t'(NUM_CORES);
    localparam csr_pkg::word_t CORE_WORD = csr_pkg::word_t'(CORE_ID);

    csr_pkg::word_t                            lwid;
    csr_pkg::word_t                            gwid;
    logic [NUM_THREADS-1:0][csr_pkg::XLEN-1:0] wtid;
    logic [NUM_THREADS-1:0][csr_pkg::XLEN-1:0] ltid;
    logic [NUM_THREADS-1:0][csr_pkg::XLEN-1:0] gtid;
    logic                                      addr_valid;

    assign rd_reg = csr_pkg::csr_decode(read_addr);
    assign rd_wid = read_wid;

    assign lwid = csr_pkg::word_t'(read_wid);
    assign gwid = CORE_WORD * NW_WORD + lwid;

    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_lane
        assign wtid[i] = csr_pkg::word_t'(i);
        assign ltid[i] = lwid * NT_WORD + csr_pkg::word_t'(i);
        assign gtid[i] = gwid * NT_WORD + csr_pkg::word_t'(i);
    end

    always_comb begin
        addr_valid = 1'b1;
        case (read_addr)
            csr_pkg::CSR_WTID:       read_data = wtid;
            csr_pkg::CSR_LTID:       read_data = ltid;
            csr_pkg::CSR_GTID:       read_data = gtid;
            csr_pkg::CSR_LWID:       read_data = {NUM_THREADS{lwid}};
            csr_pkg::CSR_GWID:       read_data = {NUM_THREADS{gwid}};
            csr_pkg::CSR_GCID:       read_data = {NUM_THREADS{CORE_WORD}};
            csr_pkg::CSR_TMASK:      read_data = {NUM_THREADS{csr_pkg::word_t'(read_tmask)}};
            csr_pkg::CSR_NT:         read_data = {NUM_THREADS{NT_WORD}};
            csr_pkg::CSR_NW:         read_data = {NUM_THREADS{NW_WORD}};
            csr_pkg::CSR_NC:         read_data = {NUM_THREADS{NC_WORD}};
            csr_pkg::CSR_MISA:       read_data = {NUM_THREADS{csr_pkg::MISA_VALUE}};
            csr_pkg::CSR_MVENDORID:  read_data = {NUM_THREADS{csr_pkg::VENDOR_ID}};
            csr_pkg::CSR_MARCHID:    read_data = {NUM_THREADS{csr_pkg::ARCHITECTURE_ID}};
            csr_pkg::CSR_MIMPID:     read_data = {NUM_THREADS{csr_pkg::IMPLEMENTATION_ID}};
            csr_pkg::CSR_MCYCLE:     read_data = {NUM_THREADS{mcycle[31:0]}};
            csr_pkg::CSR_MCYCLE_H:   read_data = {NUM_THREADS{csr_pkg::word_t'(mcycle[CTR-1:32])}};
            csr_pkg::CSR_MINSTRET:   read_data = {NUM_THREADS{minstret[31:0]}};
            csr_pkg::CSR_MINSTRET_H: read_data = {NUM_THREADS{csr_pkg::word_t'(minstret[CTR-1:32])}};
            default: begin
                // Each storage block returns zero unless rd_reg names one of its own
                read_data  = {NUM_THREADS{fcsr_rdata | machine_rdata}};
                addr_valid = (rd_reg != csr_pkg::REG_NONE);
            end
        endcase
    end

    assign read_error = read_enable && !addr_valid;

endmodule

/* design/csr_unit.sv */
module csr_unit #(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS   = 4,
    parameter int CORE_ID     = 0,
    parameter int NUM_CORES   = 1,
    localparam int NW_BITS    = csr_pkg::idx_bits(NUM_WARPS)
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       read_enable,
    input  logic [NW_BITS-1:0]                         read_wid,
    input  logic [NUM_THREADS-1:0]                     read_tmask,
    input  logic [csr_pkg::CSR_ADDR_BITS-1:0]          read_addr,
    output logic [NUM_THREADS-1:0][csr_pkg::XLEN-1:0]  read_data,
    output logic                                       read_error,
    input  logic                                       write_enable,
    input  logic [NW_BITS-1:0]                         write_wid,
    input  logic [NUM_THREADS-1:0]                     write_tmask,
    input  logic [csr_pkg::CSR_ADDR_BITS-1:0]          write_addr,
    input  logic [NUM_THREADS-1:0][csr_pkg::XLEN-1:0]  write_data,
    input  logic                                       fpu_flags_valid,
    input  logic [NW_BITS-1:0]                         fpu_flags_wid,
    input  logic [csr_pkg::FFLAGS_BITS-1:0]            fpu_fflags,
    input  logic [NW_BITS-1:0]                         fpu_read_wid,
    output logic [csr_pkg::FRM_BITS-1:0]               fpu_frm,
    input  logic                                       commit_valid
);

    csr_pkg::csr_reg_e                 wr_reg;
    csr_pkg::csr_reg_e                 rd_reg;
    logic [NW_BITS-1:0]                wr_wid;
    logic [NW_BITS-1:0]                rd_wid;
    csr_pkg::word_t                    wr_value;
    csr_pkg::word_t                    fcsr_rdata;
    csr_pkg::word_t                    machine_rdata;
    logic [csr_pkg::PERF_CTR_BITS-1:0] mcycle;
    logic [csr_pkg::PERF_CTR_BITS-1:0] minstret;

    csr_write_port #(
        .NUM_THREADS (NUM_THREADS),
        .NUM_WARPS   (NUM_WARPS)
    ) u_write_port (
        .write_enable (write_enable),
        .write_wid    (write_wid),
        .write_tmask  (write_tmask),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .wr_reg       (wr_reg),
        .wr_wid       (wr_wid),
        .wr_value     (wr_value)
    );

    csr_fcsr_bank #(
        .NUM_WARPS (NUM_WARPS)
    ) u_fcsr_bank (
        .clk             (clk),
        .reset           (reset),
        .wr_reg          (wr_reg),
        .wr_wid          (wr_wid),
        .wr_value        (wr_value),
        .fpu_flags_valid (fpu_flags_valid),
        .fpu_flags_wid   (fpu_flags_wid),
        .fpu_fflags      (fpu_fflags),
        .rd_reg          (rd_reg),
        .rd_wid          (rd_wid),
        .fpu_read_wid    (fpu_read_wid),
        .fcsr_rdata      (fcsr_rdata),
        .fpu_frm         (fpu_frm)
    );

    csr_machine_regs u_machine_regs (
        .clk           (clk),
        .reset         (reset),
        .wr_reg        (wr_reg),
        .wr_value      (wr_value),
        .rd_reg        (rd_reg),
        .machine_rdata (machine_rdata)
    );

    csr_counters u_counters (
        .clk          (clk),
        .reset        (reset),
        .commit_valid (commit_valid),
        .mcycle       (mcycle),
        .minstret     (minstret)
    );

    csr_read_mux #(
        .NUM_THREADS (NUM_THREADS),
        .NUM_WARPS   (NUM_WARPS),
        .NUM_CORES   (NUM_CORES),
        .CORE_ID     (CORE_ID)
    ) u_read_mux (
        .read_enable   (read_enable),
        .read_wid      (read_wid),
        .read_tmask    (read_tmask),
        .read_addr     (read_addr),
        .fcsr_rdata    (fcsr_rdata),
        .machine_rdata (machine_rdata),
        .mcycle        (mcycle),
        .minstret      (minstret),
        .rd_reg        (rd_reg),
        .rd_wid        (rd_wid),
        .read_data     (read_data),
        .read_error    (read_error)
    );

endmodule

/* design/csr_write_port.sv */
module csr_write_port #(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS   = 4,
    localparam int NW_BITS    = csr_pkg::idx_bits(NUM_WARPS)
) (
    input  logic                                       write_enable,
    input  logic [NW_BITS-1:0]                         write_wid,
    input  logic [NUM_THREADS-1:0]                     write_tmask,
    input  logic [csr_pkg::CSR_ADDR_BITS-1:0]          write_addr,
    input  logic [NUM_THREADS-1:0][csr_pkg::XLEN-1:0]  write_data,
    output csr_pkg::csr_reg_e                          wr_reg,
    output logic [NW_BITS-1:0]                         wr_wid,
    output csr_pkg::word_t                             wr_value
);

    // Scan from the top lane down so the lowest active lane wins
    always_comb begin
        wr_value = '0;
        for (int i = NUM_THREADS - 1; i >= 0; i--) begin
            if (write_tmask[i]) begin
                wr_value = write_data[i];
            end
        end
    end

    always_comb begin
        if (write_enable && (|write_tmask)) begin
            wr_reg = csr_pkg::csr_decode(write_addr);
        end else begin
            wr_reg = csr_pkg::REG_NONE;
        end
    end

    assign wr_wid = write_wid;

endmodule

/* flist.f */
design/csr_pkg.sv
design/csr_write_port.sv
design/csr_fcsr_bank.sv
design/csr_machine_regs.sv
design/csr_counters.sv
design/csr_read_mux.sv
design/csr_unit.sv
tests/csr_unit_tb.sv

/* tests/csr_unit_tb.sv */
module csr_unit_tb;

    localparam int NT             = 4;
    localparam int NW             = 4;
    localparam int CID            = 1;
    localparam int NC             = 2;
    localparam int WB             = 2;
    localparam int NUM_MREGS      = 9;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam logic [11:0] UNKNOWN_ADDR = 12'h7C0;

    logic                 clk;
    logic                 reset;
    logic                 read_enable;
    logic [WB-1:0]        read_wid;
    logic [NT-1:0]        read_tmask;
    logic [11:0]          read_addr;
    logic [NT-1:0][31:0]  read_data;
    logic                 read_error;
    logic                 write_enable;
    logic [WB-1:0]        write_wid;
    logic [NT-1:0]        write_tmask;
    logic [11:0]          write_addr;
    logic [NT-1:0][31:0]  write_data;
    logic                 fpu_flags_valid;
    logic [WB-1:0]        fpu_flags_wid;
    logic [4:0]           fpu_fflags;
    logic [WB-1:0]        fpu_read_wid;
    logic [2:0]           fpu_frm;
    logic                 commit_valid;

    // Reference model state
    logic [7:0]  fcsr_model [NW];
    logic [31:0] mreg_model [NUM_MREGS];
    logic [11:0] mreg_addr [NUM_MREGS];
    int          commit_count;
    int          errors;
    int          checks;
    int unsigned seed;

    csr_unit #(
        .NUM_THREADS (NT),
        .NUM_WARPS   (NW),
        .CORE_ID     (CID),
        .NUM_CORES   (NC)
    ) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [WB-1:0] random_wid();
        return WB'($urandom_range(0, NW - 1));
    endfunction

    function automatic logic [NT-1:0] random_mask();
        return NT'($urandom_range(1, (1 << NT) - 1));
    endfunction

    function automatic logic [NT-1:0][31:0] random_lanes();
        logic [NT-1:0][31:0] lanes;
        for (int i = 0; i < NT; i++) begin
            lanes[i] = $urandom;
        end
        return lanes;
    endfunction

    function automatic logic [31:0] lowest_lane_word(input logic [NT-1:0] mask,
                                                     input logic [NT-1:0][31:0] data);
        for (int i = 0; i < NT; i++) begin
            if (mask[i]) begin
                return data[i];
            end
        end
        return '0;
    endfunction

    function automatic int mreg_index(input logic [11:0] addr);
        for (int k = 0; k < NUM_MREGS; k++) begin
            if (mreg_addr[k] == addr) begin
                return k;
            end
        end
        return -1;
    endfunction

    // Unknown addresses and empty masks fall through untouched
    function automatic void apply_write(input logic [11:0] addr, input logic [WB-1:0] wid,
                                        input logic [NT-1:0] mask,
                                        input logic [NT-1:0][31:0] data);
        logic [31:0] word;
        int          k;
        if (mask == '0) begin
            return;
        end
        word = lowest_lane_word(mask, data);
        k = mreg_index(addr);
        if (k >= 0) begin
            mreg_model[k] = word;
        end else if (addr == csr_pkg::CSR_FFLAGS) begin
            fcsr_model[wid][4:0] = word[4:0];
        end else if (addr == csr_pkg::CSR_FRM) begin
            fcsr_model[wid][7:5] = word[2:0];
        end else if (addr == csr_pkg::CSR_FCSR) begin
            fcsr_model[wid] = word[7:0];
        end
    endfunction

    task automatic write_csr(input logic [11:0] addr, input logic [WB-1:0] wid,
                             input logic [NT-1:0] mask, input logic [NT-1:0][31:0] data);
        @(posedge clk);
        write_enable <= 1'b1;
        write_addr   <= addr;
        write_wid    <= wid;
        write_tmask  <= mask;
        write_data   <= data;
        @(posedge clk);
        write_enable <= 1'b0;
        apply_write(addr, wid, mask, data);
    endtask

    task automatic fpu_update(input logic [WB-1:0] wid, input logic [4:0] flags);
        @(posedge clk);
        fpu_flags_valid <= 1'b1;
        fpu_flags_wid   <= wid;
        fpu_fflags      <= flags;
        @(posedge clk);
        fpu_flags_valid <= 1'b0;
        fcsr_model[wid][4:0] = fcsr_model[wid][4:0] | flags;
    endtask

    // Outputs are combinational, so sample half a cycle after driving
    task automatic read_csr(input logic [11:0] addr, input logic [WB-1:0] wid,
                            input logic [NT-1:0] mask);
        @(posedge clk);
        read_enable  <= 1'b1;
        read_addr    <= addr;
        read_wid     <= wid;
        read_tmask   <= mask;
        fpu_read_wid <= wid;
        @(negedge clk);
    endtask

    task automatic expect_lane(input logic [11:0] addr, input int lane, input logic [31:0] exp);
        checks++;
        assert (read_data[lane] === exp) else begin
            errors++;
            $display("[FAIL] %0t: csr %h lane %0d read %h, expected %h",
                     $time, addr, lane, read_data[lane], exp);
        end
    endtask

    task automatic expect_error(input logic [11:0] addr, input logic exp);
        checks++;
        assert (read_error === exp) else begin
            errors++;
            $display("[FAIL] %0t: csr %h read_error is %b, expected %b",
                     $time, addr, read_error, exp);
        end
    endtask

    task automatic read_expect(input logic [11:0] addr, input logic [WB-1:0] wid,
                               input logic [31:0] exp);
        read_csr(addr, wid, random_mask());
        for (int i = 0; i < NT; i++) begin
            expect_lane(addr, i, exp);
        end
        expect_error(addr, 1'b0);
    endtask

    task automatic check_fcsr(input logic [WB-1:0] wid);
        read_expect(csr_pkg::CSR_FFLAGS, wid, {27'b0, fcsr_model[wid][4:0]});
        read_expect(csr_pkg::CSR_FRM, wid, {29'b0, fcsr_model[wid][7:5]});
        read_expect(csr_pkg::CSR_FCSR, wid, {24'b0, fcsr_model[wid]});
        checks++;
        assert (fpu_frm === fcsr_model[wid][7:5]) else begin
            errors++;
            $display("[FAIL] %0t: fpu_frm for warp %0d is %0d, expected %0d",
                     $time, wid, fpu_frm, fcsr_model[wid][7:5]);
        end
    endtask

    task automatic check_state();
        for (int k = 0; k < NUM_MREGS; k++) begin
            read_expect(mreg_addr[k], random_wid(), mreg_model[k]);
        end
        for (int w = 0; w < NW; w++) begin
            check_fcsr(WB'(w));
        end
    endtask

    task automatic check_idle_read();
        @(posedge clk);
        read_enable <= 1'b0;
        read_addr   <= UNKNOWN_ADDR;
        @(negedge clk);
        expect_error(UNKNOWN_ADDR, 1'b0);
    endtask

    task automatic check_identity(input logic [WB-1:0] wid);
        logic [NT-1:0] mask;
        int            gwid;
        mask = random_mask();
        gwid = CID * NW + int'(wid);
        read_csr(csr_pkg::CSR_WTID, wid, mask);
        for (int i = 0; i < NT; i++) begin
            expect_lane(csr_pkg::CSR_WTID, i, 32'(i));
        end
        read_csr(csr_pkg::CSR_LTID, wid, mask);
        for (int i = 0; i < NT; i++) begin
            expect_lane(csr_pkg::CSR_LTID, i, int'(wid) * NT + i);
        end
        read_csr(csr_pkg::CSR_GTID, wid, mask);
        for (int i = 0; i < NT; i++) begin
            expect_lane(csr_pkg::CSR_GTID, i, gwid * NT + i);
        end
        read_csr(csr_pkg::CSR_TMASK, wid, mask);
        for (int i = 0; i < NT; i++) begin
            expect_lane(csr_pkg::CSR_TMASK, i, 32'(mask));
        end
        read_expect(csr_pkg::CSR_LWID, wid, 32'(wid));
        read_expect(csr_pkg::CSR_GWID, wid, gwid);
        read_expect(csr_pkg::CSR_GCID, wid, CID);
        read_expect(csr_pkg::CSR_NT, wid, NT);
        read_expect(csr_pkg::CSR_NW, wid, NW);
        read_expect(csr_pkg::CSR_NC, wid, NC);
    endtask

    // Hold a mcycle read and count cycles until it has moved by n
    task automatic check_mcycle_step(input int n);
        logic [31:0] first;
        int          waited;
        read_csr(csr_pkg::CSR_MCYCLE, '0, '1);
        first = read_data[0];
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (read_data[0] !== first + 32'(n) && waited <= n + 20);
        checks++;
        if (waited > n + 20) begin
            errors++;
            $display("Timeout: mcycle did not advance by %0d within %0d cycles", n, waited);
        end else begin
            assert (waited == n) else begin
                errors++;
                $display("[FAIL] %0t: mcycle advanced by %0d in %0d cycles", $time, n, waited);
            end
        end
    endtask

    initial begin
        logic [11:0]         addr;
        logic [NT-1:0]       mask;
        logic [NT-1:0][31:0] data;
        logic                pulse;
        seed = $urandom(65297);
        mreg_addr = '{csr_pkg::CSR_SATP, csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MEDELEG,
                      csr_pkg::CSR_MIDELEG, csr_pkg::CSR_MIE, csr_pkg::CSR_MTVEC,
                      csr_pkg::CSR_MEPC, csr_pkg::CSR_PMPCFG0, csr_pkg::CSR_PMPADDR0};
        errors = 0;
        checks = 0;
        commit_count = 0;
        for (int w = 0; w < NW; w++) begin
            fcsr_model[w] = '0;
        end
        for (int k = 0; k < NUM_MREGS; k++) begin
            mreg_model[k] = '0;
        end
        reset = 1'b1;
        read_enable = 1'b0;
        read_wid = '0;
        read_tmask = '0;
        read_addr = '0;
        write_enable = 1'b0;
        write_wid = '0;
        write_tmask = '0;
        write_addr = '0;
        write_data = '0;
        fpu_flags_valid = 1'b0;
        fpu_flags_wid = '0;
        fpu_fflags = '0;
        fpu_read_wid = '0;
        commit_valid = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        check_state();
        check_idle_read();
        for (int k = 0; k < NUM_MREGS; k++) begin
            write_csr(mreg_addr[k], random_wid(), random_mask(), random_lanes());
        end
        check_state();
        // Known nonzero fcsr in warp 2
        write_csr(csr_pkg::CSR_FCSR, 2'd2, '1, {NT{32'h0000_00A5}});
        // Empty thread mask
        write_csr(csr_pkg::CSR_MEPC, random_wid(), '0, random_lanes());
        write_csr(csr_pkg::CSR_FCSR, 2'd2, '0, random_lanes());
        check_state();

        for (int n = 0; n < 12; n++) begin
            case (n % 3)
                0:       addr = csr_pkg::CSR_FRM;
                1:       addr = csr_pkg::CSR_FFLAGS;
                default: addr = csr_pkg::CSR_FCSR;
            endcase
            write_csr(addr, random_wid(), random_mask(), random_lanes());
        end
        check_state();

        for (int n = 0; n < 8; n++) begin
            fpu_update(random_wid(), 5'($urandom));
        end
        check_state();

        // Core FFLAGS write and FPU update on the same warp and cycle
        mask = random_mask();
        data = random_lanes();
        @(posedge clk);
        write_enable    <= 1'b1;
        write_addr      <= csr_pkg::CSR_FFLAGS;
        write_wid       <= 2'd1;
        write_tmask     <= mask;
        write_data      <= data;
        fpu_flags_valid <= 1'b1;
        fpu_flags_wid   <= 2'd1;
        fpu_fflags      <= 5'h1F;
        @(posedge clk);
        write_enable    <= 1'b0;
        fpu_flags_valid <= 1'b0;
        apply_write(csr_pkg::CSR_FFLAGS, 2'd1, mask, data);
        check_state();

        for (int w = 0; w < NW; w++) begin
            check_identity(WB'(w));
        end
        read_expect(csr_pkg::CSR_MISA, '0, csr_pkg::MISA_VALUE);
        read_expect(csr_pkg::CSR_MVENDORID, '0, csr_pkg::VENDOR_ID);
        read_expect(csr_pkg::CSR_MARCHID, '0, csr_pkg::ARCHITECTURE_ID);
        read_expect(csr_pkg::CSR_MIMPID, '0, csr_pkg::IMPLEMENTATION_ID);

        check_mcycle_step(7);
        check_mcycle_step(25);
        for (int n = 0; n < 24; n++) begin
            pulse = 1'($urandom);
            @(posedge clk);
            commit_valid <= pulse;
            if (pulse) begin
                commit_count++;
            end
        end
        @(posedge clk);
        commit_valid <= 1'b0;
        read_expect(csr_pkg::CSR_MINSTRET, '0, 32'(commit_count));
        read_expect(csr_pkg::CSR_MINSTRET_H, '0, '0);
        read_expect(csr_pkg::CSR_MCYCLE_H, '0, '0);

        read_csr(UNKNOWN_ADDR, random_wid(), random_mask());
        for (int i = 0; i < NT; i++) begin
            expect_lane(UNKNOWN_ADDR, i, '0);
        end
        expect_error(UNKNOWN_ADDR, 1'b1);
        write_csr(UNKNOWN_ADDR, random_wid(), random_mask(), random_lanes());
        check_state();
        check_idle_read();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
